//--- hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // datapath width, set by the 16-bit instruction word
  localparam int data_w = 16;

  // opcode field in bits 15:12
  // unlisted codes (0011, 0111, 1101, 1110) retire as no-ops
  typedef enum logic [3:0] {
    ADD = 4'b0000,
    SUB = 4'b0001,
    XOR = 4'b0010,
    SLL = 4'b0100,
    SRA = 4'b0101,
    ROR = 4'b0110,
    LW  = 4'b1000,
    SW  = 4'b1001,
    LLB = 4'b1010,
    LHB = 4'b1011,
    B   = 4'b1100,
    HLT = 4'b1111
  } opcode_e;

  // register view, rt doubles as the 4-bit shift or offset immediate
  typedef struct packed {
    opcode_e    op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } instr_reg_t;

  // byte view for llb and lhb
  typedef struct packed {
    opcode_e    op;
    logic [3:0] rd;
    logic [7:0] imm8;
  } instr_byte_t;

  // branch view, offset counts instruction words
  typedef struct packed {
    opcode_e           op;
    logic [2:0]        cond;
    logic signed [8:0] off;
  } instr_br_t;

  typedef union packed {
    instr_reg_t  r;
    instr_byte_t y;
    instr_br_t   b;
  } instr_u;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  // decode to execute
  typedef struct packed {
    opcode_e           op;
    logic [3:0]        rd;
    logic [3:0]        rs;
    logic [3:0]        rt;
    logic [data_w-1:0] rs_data;
    logic [data_w-1:0] rt_data;
    logic [data_w-1:0] imm;
    logic              use_imm;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              hlt;
  } id_ex_t;

  // execute to memory, result holds the address for lw and sw
  typedef struct packed {
    logic [data_w-1:0] result;
    logic [data_w-1:0] store_data;
    logic [3:0]        rd;
    logic              mem_read;
    logic              mem_write;
    logic              reg_write;
    logic              hlt;
  } ex_mem_t;

  // memory to writeback
  typedef struct packed {
    logic [data_w-1:0] alu_result;
    logic [3:0]        rd;
    logic              load_sel;
    logic              reg_write;
    logic              hlt;
  } mem_wb_t;

  // one register write leaving writeback
  typedef struct packed {
    logic              we;
    logic [3:0]        rd;
    logic [data_w-1:0] data;
  } retire_t;

endpackage

`default_nettype wire

//--- hw/alu.sv
`default_nettype none

module alu (
  input  cpu_pkg::opcode_e           op,
  input  logic [cpu_pkg::data_w-1:0] a,
  input  logic [cpu_pkg::data_w-1:0] b,
  output logic [cpu_pkg::data_w-1:0] result,
  output cpu_pkg::flags_t            alu_flags,
  output cpu_pkg::flags_t            flag_en
);

  logic [cpu_pkg::data_w-1:0]   sum;
  logic [cpu_pkg::data_w-1:0]   diff;
  logic [cpu_pkg::data_w-1:0]   sat_val;
  logic [2*cpu_pkg::data_w-1:0] rot;
  logic [3:0]                   sh;
  logic                         add_ovf;
  logic                         sub_ovf;

  assign sum  = a + b;
  assign diff = a - b;
  // signed overflow from operand and result signs
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);
  // on overflow the true result has the sign of a
  assign sat_val = a[15] ? 16'h8000 : 16'h7fff;
  assign sh      = b[3:0];
  assign rot     = {a, a} >> sh;

  always_comb begin
    alu_flags.v = 1'b0;
    case (op)
      cpu_pkg::ADD: begin
        result      = add_ovf ? sat_val : sum;
        alu_flags.v = add_ovf;
      end
      cpu_pkg::SUB: begin
        result      = sub_ovf ? sat_val : diff;
        alu_flags.v = sub_ovf;
      end
      cpu_pkg::XOR: result = a ^ b;
      cpu_pkg::SLL: result = a << sh;
      cpu_pkg::SRA: result = $signed(a) >>> sh;
      cpu_pkg::ROR: result = rot[cpu_pkg::data_w-1:0];
      // a carries the old rd, b[7:0] the byte immediate
      cpu_pkg::LLB: result = {a[15:8], b[7:0]};
      cpu_pkg::LHB: result = {b[7:0], a[7:0]};
      // base plus scaled offset
      cpu_pkg::LW,
      cpu_pkg::SW:  result = sum;
      default:      result = '0;
    endcase
    alu_flags.z = (result == '0);
    alu_flags.n = result[15];
  end

  always_comb begin
    flag_en = '0;
    if (op inside {cpu_pkg::ADD, cpu_pkg::SUB}) begin
      flag_en.z = 1'b1;
      flag_en.n = 1'b1;
      flag_en.v = 1'b1;
    end else if (op inside {cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR}) begin
      flag_en.z = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [cpu_pkg::data_w-1:0] instr_rdata,
  input  logic                       stall,
  input  logic                       branch_taken,
  input  logic [cpu_pkg::data_w-1:0] branch_target,
  output logic [cpu_pkg::data_w-1:0] pc,
  output cpu_pkg::instr_u            id_instr,
  output logic [cpu_pkg::data_w-1:0] id_pc
);

  // unused opcode 0011, decodes with no side effects
  localparam logic [15:0] nop_word = 16'h3000;

  logic            squash;
  logic            replay;
  logic            halted;
  logic            id_is_hlt;
  cpu_pkg::instr_u replay_instr;

  // word in decode belongs to the pc of the previous cycle
  always_comb begin
    if (squash || halted)
      id_instr = nop_word;
    else if (replay)
      id_instr = replay_instr;
    else
      id_instr = instr_rdata;
  end

  assign id_is_hlt = (id_instr.r.op == cpu_pkg::HLT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= '0;
      id_pc  <= '0;
      // first word after reset was sampled before pc started
      squash <= 1'b1;
      replay <= 1'b0;
      halted <= 1'b0;
    end else begin
      // kill the wrong-path word arriving next cycle
      squash <= branch_taken;
      replay <= stall;
      if (id_is_hlt && !stall)
        halted <= 1'b1;
      if (!stall) begin
        id_pc <= pc;
        if (branch_taken)
          pc <= branch_target;
        else if (!(id_is_hlt || halted))
          pc <= pc + 16'd2;
      end
    end
  end

  // hold the stalled decode word for one more cycle
  always_ff @(posedge clk) begin
    if (stall)
      replay_instr <= id_instr;
  end

endmodule

`default_nettype wire

//--- hw/decode_unit.sv
`default_nettype none

module decode_unit (
  input  cpu_pkg::instr_u            id_instr,
  input  logic [cpu_pkg::data_w-1:0] id_pc,
  input  logic [cpu_pkg::data_w-1:0] rs_data,
  input  logic [cpu_pkg::data_w-1:0] rt_data,
  input  cpu_pkg::flags_t            flags,
  input  logic                       stall,
  output logic [3:0]                 rs,
  output logic [3:0]                 rt,
  output cpu_pkg::id_ex_t            id_ex,
  output logic                       branch_taken,
  output logic [cpu_pkg::data_w-1:0] branch_target
);

  cpu_pkg::opcode_e            op;
  logic                        is_rr;
  logic                        is_shift;
  logic                        is_mem;
  logic                        is_byte;
  logic                        is_branch;
  logic                        cond_met;
  logic [cpu_pkg::data_w-1:0]  imm;
  logic [cpu_pkg::data_w-1:0]  br_off;

  assign op        = id_instr.r.op;
  assign is_rr     = op inside {cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::XOR};
  assign is_shift  = op inside {cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR};
  assign is_mem    = op inside {cpu_pkg::LW, cpu_pkg::SW};
  assign is_byte   = op inside {cpu_pkg::LLB, cpu_pkg::LHB};
  assign is_branch = (op == cpu_pkg::B);

  // register numbers stay 0 when a field is not a source,
  // so hazard checks see no false match
  always_comb begin
    rs = 4'd0;
    rt = 4'd0;
    if (is_rr || is_shift || is_mem)
      rs = id_instr.r.rs;
    else if (is_byte)
      rs = id_instr.r.rd;
    // sw stores the register named in bits 11:8
    if (is_rr)
      rt = id_instr.r.rt;
    else if (op == cpu_pkg::SW)
      rt = id_instr.r.rd;
  end

  always_comb begin
    if (is_mem)
      // word offset, sign extended and scaled to bytes
      imm = {{11{id_instr.r.rt[3]}}, id_instr.r.rt, 1'b0};
    else if (is_byte)
      imm = {8'h00, id_instr.y.imm8};
    else
      imm = {12'h000, id_instr.r.rt};
  end

  always_comb begin
    id_ex.op        = op;
    id_ex.rd        = id_instr.r.rd;
    id_ex.rs        = rs;
    id_ex.rt        = rt;
    id_ex.rs_data   = rs_data;
    id_ex.rt_data   = rt_data;
    id_ex.imm       = imm;
    id_ex.use_imm   = is_shift || is_mem || is_byte;
    id_ex.mem_read  = (op == cpu_pkg::LW);
    id_ex.mem_write = (op == cpu_pkg::SW);
    id_ex.reg_write = is_rr || is_shift || is_byte || (op == cpu_pkg::LW);
    id_ex.hlt       = (op == cpu_pkg::HLT);
  end

  // ne, eq, gt, lt, ge, le, overflow, always
  always_comb begin
    case (id_instr.b.cond)
      3'b000:  cond_met = !flags.z;
      3'b001:  cond_met = flags.z;
      3'b010:  cond_met = !flags.z && !flags.n;
      3'b011:  cond_met = flags.n;
      3'b100:  cond_met = flags.z || !flags.n;
      3'b101:  cond_met = flags.n || flags.z;
      3'b110:  cond_met = flags.v;
      default: cond_met = 1'b1;
    endcase
  end

  assign br_off        = {{6{id_instr.b.off[8]}}, id_instr.b.off, 1'b0};
  assign branch_target = id_pc + 16'd2 + br_off;
  // flags may still be in flight while stalled
  assign branch_taken  = is_branch && cond_met && !stall;

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

module register_file (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [3:0]                 rs,
  input  logic [3:0]                 rt,
  output logic [cpu_pkg::data_w-1:0] rs_data,
  output logic [cpu_pkg::data_w-1:0] rt_data,
  input  cpu_pkg::retire_t           wb,
  input  cpu_pkg::flags_t            alu_flags,
  input  cpu_pkg::flags_t            flag_en,
  output cpu_pkg::flags_t            flags
);

  logic [cpu_pkg::data_w-1:0] regs [16];

  // r0 reads zero, a same-cycle writeback wins over the stored word
  function automatic logic [cpu_pkg::data_w-1:0] read_reg(input logic [3:0] sel);
    logic [cpu_pkg::data_w-1:0] val;
    if (sel == 4'd0)
      val = '0;
    else if (wb.we && wb.rd == sel)
      val = wb.data;
    else
      val = regs[sel];
    return val;
  endfunction

  always_comb begin
    rs_data = read_reg(rs);
    rt_data = read_reg(rt);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++)
        regs[i] <= '0;
      flags <= '0;
    end else begin
      if (wb.we && wb.rd != 4'd0)
        regs[wb.rd] <= wb.data;
      // each flag updates only when execute enables it
      if (flag_en.z)
        flags.z <= alu_flags.z;
      if (flag_en.n)
        flags.n <= alu_flags.n;
      if (flag_en.v)
        flags.v <= alu_flags.v;
    end
  end

endmodule

`default_nettype wire

//--- hw/forward_unit.sv
`default_nettype none

module forward_unit (
  input  logic [3:0] ex_rs,
  input  logic [3:0] ex_rt,
  input  logic [3:0] ex_rd,
  input  logic [3:0] mem_rd,
  input  logic       mem_reg_write,
  input  logic [3:0] wb_rd,
  input  logic       wb_reg_write,
  input  logic       ex_mem_read,
  input  logic       ex_sets_flags,
  input  logic [3:0] id_rs,
  input  logic [3:0] id_rt,
  input  logic       id_is_branch,
  output logic [1:0] fwd_rs,
  output logic [1:0] fwd_rt,
  output logic       stall
);

  logic load_use;
  logic flag_hazard;

  // bit 1 takes the memory-stage result, bit 0 the writeback data
  // the newer memory stage wins when both match
  function automatic logic [1:0] pick(input logic [3:0] src);
    logic [1:0] sel;
    sel = 2'b00;
    if (src != 4'd0) begin
      if (mem_reg_write && mem_rd == src)
        sel = 2'b10;
      else if (wb_reg_write && wb_rd == src)
        sel = 2'b01;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_rs = pick(ex_rs);
    fwd_rt = pick(ex_rt);
  end

  // load data only exists in writeback, so a direct consumer waits one cycle
  assign load_use = ex_mem_read && (ex_rd != 4'd0) &&
                    ((ex_rd == id_rs) || (ex_rd == id_rt));

  // branch reads the flag register, which execute has not written yet
  assign flag_hazard = id_is_branch && ex_sets_flags;

  assign stall = load_use || flag_hazard;

endmodule

`default_nettype wire

//--- hw/cpu.sv
`default_nettype none

module cpu (
  input  logic                       clk,
  input  logic                       rst_n,
  output logic [cpu_pkg::data_w-1:0] pc,
  input  logic [cpu_pkg::data_w-1:0] instr_rdata,
  output logic [cpu_pkg::data_w-1:0] dmem_addr,
  output logic [cpu_pkg::data_w-1:0] dmem_wdata,
  output logic                       dmem_we,
  input  logic [cpu_pkg::data_w-1:0] dmem_rdata,
  output cpu_pkg::retire_t           retire,
  output logic                       hlt
);

  cpu_pkg::instr_u            id_instr;
  logic [cpu_pkg::data_w-1:0] id_pc;
  logic [3:0]                 id_rs;
  logic [3:0]                 id_rt;
  logic [cpu_pkg::data_w-1:0] rs_data;
  logic [cpu_pkg::data_w-1:0] rt_data;
  logic                       id_is_branch;
  logic                       branch_taken;
  logic [cpu_pkg::data_w-1:0] branch_target;
  cpu_pkg::flags_t            flags;
  cpu_pkg::flags_t            alu_flags;
  cpu_pkg::flags_t            alu_flag_en;
  cpu_pkg::flags_t            ex_flag_en;
  cpu_pkg::id_ex_t            id_ex;
  cpu_pkg::id_ex_t            id_ex_in;
  cpu_pkg::id_ex_t            id_ex_q;
  cpu_pkg::ex_mem_t           ex_mem_q;
  cpu_pkg::mem_wb_t           mem_wb_q;
  logic                       stall;
  logic [1:0]                 fwd_rs;
  logic [1:0]                 fwd_rt;
  logic [cpu_pkg::data_w-1:0] op_a;
  logic [cpu_pkg::data_w-1:0] op_rt;
  logic [cpu_pkg::data_w-1:0] alu_b;
  logic [cpu_pkg::data_w-1:0] alu_result;
  logic [cpu_pkg::data_w-1:0] wb_data;
  logic                       hlt_q;

  fetch_unit u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_rdata  (instr_rdata),
    .stall        (stall),
    .branch_taken (branch_taken),
    .branch_target(branch_target),
    .pc           (pc),
    .id_instr     (id_instr),
    .id_pc        (id_pc)
  );

  decode_unit u_decode (
    .id_instr     (id_instr),
    .id_pc        (id_pc),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .flags        (flags),
    .stall        (stall),
    .rs           (id_rs),
    .rt           (id_rt),
    .id_ex        (id_ex),
    .branch_taken (branch_taken),
    .branch_target(branch_target)
  );

  register_file u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs       (id_rs),
    .rt       (id_rt),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .wb       (retire),
    .alu_flags(alu_flags),
    .flag_en  (ex_flag_en),
    .flags    (flags)
  );

  assign id_is_branch = (id_instr.b.op == cpu_pkg::B);

  forward_unit u_fwd (
    .ex_rs        (id_ex_q.rs),
    .ex_rt        (id_ex_q.rt),
    .ex_rd        (id_ex_q.rd),
    .mem_rd       (ex_mem_q.rd),
    .mem_reg_write(ex_mem_q.reg_write),
    .wb_rd        (mem_wb_q.rd),
    .wb_reg_write (mem_wb_q.reg_write),
    .ex_mem_read  (id_ex_q.mem_read),
    .ex_sets_flags(|ex_flag_en),
    .id_rs        (id_rs),
    .id_rt        (id_rt),
    .id_is_branch (id_is_branch),
    .fwd_rs       (fwd_rs),
    .fwd_rt       (fwd_rt),
    .stall        (stall)
  );

  // execute operands, newest value first
  assign op_a  = fwd_rs[1] ? ex_mem_q.result :
                 fwd_rs[0] ? wb_data : id_ex_q.rs_data;
  assign op_rt = fwd_rt[1] ? ex_mem_q.result :
                 fwd_rt[0] ? wb_data : id_ex_q.rt_data;
  assign alu_b = id_ex_q.use_imm ? id_ex_q.imm : op_rt;

  alu u_alu (
    .op       (id_ex_q.op),
    .a        (op_a),
    .b        (alu_b),
    .result   (alu_result),
    .alu_flags(alu_flags),
    .flag_en  (alu_flag_en)
  );

  // bubbles carry a stale opcode but never reg_write
  assign ex_flag_en = id_ex_q.reg_write ? alu_flag_en : '0;

  // stall turns the decode slot into a bubble
  always_comb begin
    id_ex_in = id_ex;
    if (stall) begin
      id_ex_in.mem_read  = 1'b0;
      id_ex_in.mem_write = 1'b0;
      id_ex_in.reg_write = 1'b0;
      id_ex_in.hlt       = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_q  <= '0;
      ex_mem_q <= '0;
      mem_wb_q <= '0;
      hlt_q    <= 1'b0;
    end else begin
      id_ex_q  <= id_ex_in;
      ex_mem_q <= '{
        result:     alu_result,
        store_data: op_rt,
        rd:         id_ex_q.rd,
        mem_read:   id_ex_q.mem_read,
        mem_write:  id_ex_q.mem_write,
        reg_write:  id_ex_q.reg_write,
        hlt:        id_ex_q.hlt
      };
      mem_wb_q <= '{
        alu_result: ex_mem_q.result,
        rd:         ex_mem_q.rd,
        load_sel:   ex_mem_q.mem_read,
        reg_write:  ex_mem_q.reg_write,
        hlt:        ex_mem_q.hlt
      };
      if (mem_wb_q.hlt)
        hlt_q <= 1'b1;
    end
  end

  // data memory sees the EX/MEM register directly
  assign dmem_addr  = ex_mem_q.result;
  assign dmem_wdata = ex_mem_q.store_data;
  assign dmem_we    = ex_mem_q.mem_write;

  // read word returns in the writeback cycle
  assign wb_data = mem_wb_q.load_sel ? dmem_rdata : mem_wb_q.alu_result;

  assign retire.we   = mem_wb_q.reg_write && (mem_wb_q.rd != 4'd0);
  assign retire.rd   = mem_wb_q.rd;
  assign retire.data = wb_data;

  // high from the halt's writeback cycle on
  assign hlt = hlt_q || mem_wb_q.hlt;

endmodule

`default_nettype wire

//--- testbench/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// clamp a true sum to the signed 16-bit range
// bit 16 tells that the clamp took place
function automatic logic [16:0] saturate(input int s);
  logic [16:0] r;
  if (s > 32767)
    r = {1'b1, 16'h7fff};
  else if (s < -32768)
    r = {1'b1, 16'h8000};
  else
    r = {1'b0, s[15:0]};
  return r;
endfunction

// cond field order: ne, eq, gt, lt, ge, le, overflow, always
function automatic logic cond_holds(input logic [2:0] cond, input logic z,
                                    input logic n, input logic v);
  logic hold;
  case (cond)
    3'd0:    hold = !z;
    3'd1:    hold = z;
    3'd2:    hold = !z && !n;
    3'd3:    hold = n;
    3'd4:    hold = !n || z;
    3'd5:    hold = n || z;
    3'd6:    hold = v;
    default: hold = 1'b1;
  endcase
  return hold;
endfunction

// walks imem from word 0 up to hlt, one instruction per step,
// on private copies of registers, flags and data memory
function automatic void run_reference();
  logic [15:0]      regs [16];
  logic [15:0]      mem [256];
  logic [15:0]      w;
  logic [15:0]      a;
  logic [15:0]      res;
  logic [15:0]      addr;
  logic [3:0]       rd;
  logic             wr;
  logic             z;
  logic             n;
  logic             v;
  int               idx;
  cpu_pkg::retire_t ent;
  exp_retire.delete();
  exp_store.delete();
  for (int i = 0; i < 16; i++)
    regs[4'(i)] = '0;
  for (int i = 0; i < 256; i++)
    mem[8'(i)] = dmem[8'(i)];
  z   = 1'b0;
  n   = 1'b0;
  v   = 1'b0;
  idx = 0;
  // branches only go forward, so prog_len steps always reach hlt
  for (int step = 0; step < prog_len; step++) begin
    w    = imem[idx[7:0]];
    rd   = w[11:8];
    a    = regs[w[7:4]];
    wr   = 1'b1;
    res  = '0;
    // word offset counts two bytes per step
    addr = a + 16'(int'($signed(w[3:0])) * 2);
    idx  = idx + 1;
    case (w[15:12])
      cpu_pkg::ADD: begin
        {v, res} = saturate(int'($signed(a)) + int'($signed(regs[w[3:0]])));
        z = (res == 16'h0000);
        n = res[15];
      end
      cpu_pkg::SUB: begin
        {v, res} = saturate(int'($signed(a)) - int'($signed(regs[w[3:0]])));
        z = (res == 16'h0000);
        n = res[15];
      end
      cpu_pkg::XOR: begin
        res = a ^ regs[w[3:0]];
        z   = (res == 16'h0000);
      end
      cpu_pkg::SLL: begin
        res = a << w[3:0];
        z   = (res == 16'h0000);
      end
      cpu_pkg::SRA: begin
        res = $signed(a) >>> w[3:0];
        z   = (res == 16'h0000);
      end
      cpu_pkg::ROR: begin
        res = a;
        // one bit at a time, lsb wraps into the msb
        repeat (int'(w[3:0]))
          res = {res[0], res[15:1]};
        z = (res == 16'h0000);
      end
      cpu_pkg::LW:  res = mem[addr[8:1]];
      cpu_pkg::SW: begin
        wr = 1'b0;
        mem[addr[8:1]] = regs[rd];
        exp_store.push_back({addr, regs[rd]});
      end
      cpu_pkg::LLB: res = {regs[rd][15:8], w[7:0]};
      cpu_pkg::LHB: res = {w[7:0], regs[rd][7:0]};
      cpu_pkg::B: begin
        wr = 1'b0;
        if (cond_holds(w[11:9], z, n, v))
          idx = idx + int'($signed(w[8:0]));
      end
      cpu_pkg::HLT: return;
      default:      wr = 1'b0;
    endcase
    // r0 never takes a write and never shows on the retire port
    if (wr && rd != 4'd0) begin
      regs[rd] = res;
      ent.we   = 1'b1;
      ent.rd   = rd;
      ent.data = res;
      exp_retire.push_back(ent);
    end
  end
endfunction

`endif

//--- testbench/tb_cpu.sv
`default_nettype none

module tb_cpu;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int period       = 20;
  localparam int reset_cycles = 10;
  localparam int num_progs    = 20;
  localparam int prog_len     = 60;
  localparam int drain        = 8;
  // 4 cycles per instruction is far above any stall and squash mix
  localparam int limit_cycles =
    num_progs * (prog_len * 4 + reset_cycles + drain + 2) + 100;

  logic             clk;
  logic             rst_n;
  logic [15:0]      pc;
  logic [15:0]      instr_rdata;
  logic [15:0]      dmem_addr;
  logic [15:0]      dmem_wdata;
  logic             dmem_we;
  logic [15:0]      dmem_rdata;
  cpu_pkg::retire_t retire;
  logic             hlt;

  logic [15:0]      imem [256];
  logic [15:0]      dmem [256];
  logic [31:0]      lcg_state;
  cpu_pkg::retire_t exp_retire [$];
  // {address, data} per store
  logic [31:0]      exp_store [$];
  logic             running;
  int               cmp_errors;
  int               end_errors;
  int               retire_seen;
  int               prog_num;
  // port values seen by the memories one cycle back
  logic [15:0]      pc_seen;
  logic [15:0]      addr_seen;
  logic [15:0]      wdata_seen;
  logic             we_seen;

  `include "isa_model.svh"

  cpu DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .instr_rdata(instr_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata),
    .retire     (retire),
    .hlt        (hlt)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // 59 random words then hlt and only forward branches
  task automatic build_program();
    logic [15:0] r;
    logic [15:0] f;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [3:0]  rs;
    int          span;
    int          off;
    // spare words hold an unused opcode tagged with their address
    for (int i = 0; i < 256; i++) begin
      imem[8'(i)] = {4'h3, 4'h0, 8'(i)};
      dmem[8'(i)] = next_rand();
    end
    for (int i = 0; i < prog_len - 1; i++) begin
      r  = next_rand();
      f  = next_rand();
      op = r[3:0];
      // only the last word halts
      if (op == cpu_pkg::HLT)
        op = cpu_pkg::LLB;
      // eight registers keep dependences close together
      rd = {1'b0, r[6:4]};
      rs = {1'b0, r[9:7]};
      case (op)
        cpu_pkg::B: begin
          // target never passes the hlt word
          span = prog_len - 2 - i;
          if (span > 3)
            span = 3;
          off = int'(f) % (span + 1);
          imem[8'(i)] = {op, f[15:13], 9'(off)};
        end
        cpu_pkg::LLB, cpu_pkg::LHB:
          imem[8'(i)] = {op, rd, f[7:0]};
        cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::XOR:
          imem[8'(i)] = {op, rd, rs, 1'b0, f[2:0]};
        default:
          imem[8'(i)] = {op, rd, rs, f[3:0]};
      endcase
    end
    imem[8'(prog_len - 1)] = {cpu_pkg::HLT, 12'h000};
  endtask

  // both memories act on the rising edge and answer 1 ns later
  initial begin
    instr_rdata = '0;
    dmem_rdata  = '0;
    pc_seen     = '0;
    addr_seen   = '0;
    wdata_seen  = '0;
    we_seen     = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      instr_rdata = imem[pc_seen[8:1]];
      if (we_seen)
        dmem[addr_seen[8:1]] = wdata_seen;
      dmem_rdata = dmem[addr_seen[8:1]];
      pc_seen    = pc;
      addr_seen  = dmem_addr;
      wdata_seen = dmem_wdata;
      we_seen    = dmem_we;
    end
  end

  task automatic compare_retire();
    cpu_pkg::retire_t exp;
    retire_seen++;
    if (exp_retire.size() == 0) begin
      cmp_errors++;
      $display("program %0d: unexpected write of r%0d after the last expected write",
               prog_num, retire.rd);
      return;
    end
    exp = exp_retire.pop_front();
    if (retire.rd != exp.rd) begin
      cmp_errors++;
      $display("[ERROR] retire.rd: expected 0x%01h, got 0x%01h", exp.rd, retire.rd);
    end
    if (retire.data != exp.data) begin
      cmp_errors++;
      $display("[ERROR] retire.data: expected 0x%04h, got 0x%04h (r%0d)",
               exp.data, retire.data, exp.rd);
    end
  endtask

  task automatic compare_store();
    logic [31:0] exp;
    if (exp_store.size() == 0) begin
      cmp_errors++;
      $display("program %0d: unexpected store to 0x%04h", prog_num, dmem_addr);
      return;
    end
    exp = exp_store.pop_front();
    if (dmem_addr != exp[31:16]) begin
      cmp_errors++;
      $display("[ERROR] dmem_addr: expected 0x%04h, got 0x%04h", exp[31:16], dmem_addr);
    end
    if (dmem_wdata != exp[15:0]) begin
      cmp_errors++;
      $display("[ERROR] dmem_wdata: expected 0x%04h, got 0x%04h", exp[15:0], dmem_wdata);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (!rst_n) begin
      if (pc != 16'h0000) begin
        cmp_errors++;
        $display("[ERROR] pc: expected 0x0000, got 0x%04h", pc);
      end
      if (retire.we) begin
        cmp_errors++;
        $display("[ERROR] retire.we: expected 0x0, got 0x%01h", retire.we);
      end
      if (dmem_we) begin
        cmp_errors++;
        $display("[ERROR] dmem_we: expected 0x0, got 0x%01h", dmem_we);
      end
      if (hlt) begin
        cmp_errors++;
        $display("[ERROR] hlt: expected 0x0, got 0x%01h", hlt);
      end
    end else if (running) begin
      if (retire.we)
        compare_retire();
      if (dmem_we)
        compare_store();
    end
  end

  task automatic run_program();
    int          cycles;
    int          retire_base;
    logic [15:0] pc_at_halt;
    running = 1'b0;
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    @(negedge clk);
    build_program();
    run_reference();
    retire_base = retire_seen;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n   = 1'b1;
    running = 1'b1;
    cycles  = 0;
    while (!hlt && cycles < prog_len * 4) begin
      @(negedge clk);
      cycles++;
    end
    if (!hlt) begin
      end_errors++;
      $display("program %0d: hlt did not rise within %0d cycles", prog_num, cycles);
    end else begin
      // halt holds and pc stays frozen
      pc_at_halt = pc;
      repeat (drain) begin
        @(negedge clk);
        if (!hlt) begin
          end_errors++;
          $display("[ERROR] hlt: expected 0x1, got 0x0");
        end
        if (pc != pc_at_halt) begin
          end_errors++;
          $display("[ERROR] pc: expected 0x%04h, got 0x%04h", pc_at_halt, pc);
        end
      end
    end
    if (exp_retire.size() != 0) begin
      end_errors++;
      $display("program %0d: %0d expected register writes never retired",
               prog_num, exp_retire.size());
    end
    if (exp_store.size() != 0) begin
      end_errors++;
      $display("program %0d: %0d expected stores never reached the data port",
               prog_num, exp_store.size());
    end
    if (retire_seen - retire_base == 0) begin
      end_errors++;
      $display("program %0d: no register write retired at all", prog_num);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    running     = 1'b0;
    lcg_state   = 32'd99232;
    cmp_errors  = 0;
    end_errors  = 0;
    retire_seen = 0;
    for (prog_num = 0; prog_num < num_progs; prog_num++)
      run_program();
    $display("programs %0d, retired %0d, compare errors %0d, end-of-program errors %0d",
             num_progs, retire_seen, cmp_errors, end_errors);
    if (cmp_errors == 0 && end_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // bounds the whole run
  initial begin
    #(limit_cycles * period);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+testbench
hw/cpu_pkg.sv
hw/alu.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/register_file.sv
hw/forward_unit.sv
hw/cpu.sv
testbench/tb_cpu.sv

//--- run.sh
#!/bin/sh
# builds the cpu testbench with Verilator, runs it, and checks the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --timescale 1ns/100ps \
  --top-module tb_cpu \
  -f src.f \
  -o tb_cpu

./obj_dir/tb_cpu > sim.log 2>&1
cat sim.log

if grep -q '^RESULT: PASS$' sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1
